/* Bender.yml */
package:
  name: vga_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/vga_pkg.sv
      - design/vga_cfg_regs.sv
      - design/vga_timing_gen.sv
      - design/vga_pattern_gen.sv
      - design/vga_sync_checker.sv
      - design/vga_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/vga_top_tb.sv

/* design/vga_cfg_regs.sv */
`timescale 1ns/100ps
`include "vga_consts.svh"

module vga_cfg_regs (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   cfg_we,
   input  logic [`VGA_ADDR_W-1:0] cfg_addr,
   input  logic [`VGA_DATA_W-1:0] cfg_wdata,
   input  logic                   frame_start,
   output vga_pkg::timing_t       timing,
   output vga_pkg::pattern_e      pattern,
   output logic                   enable
);

   // 640x480 values loaded at reset
   localparam vga_pkg::timing_t def_timing = '{
      h_act: `VGA_CNT_W'(`VGA_DEF_H_ACT),
      h_fp:  `VGA_CNT_W'(`VGA_DEF_H_FP),
      h_pw:  `VGA_CNT_W'(`VGA_DEF_H_PW),
      h_bp:  `VGA_CNT_W'(`VGA_DEF_H_BP),
      v_act: `VGA_CNT_W'(`VGA_DEF_V_ACT),
      v_fp:  `VGA_CNT_W'(`VGA_DEF_V_FP),
      v_pw:  `VGA_CNT_W'(`VGA_DEF_V_PW),
      v_bp:  `VGA_CNT_W'(`VGA_DEF_V_BP)
   };

   vga_pkg::timing_t      staged;
   logic [`VGA_CNT_W-1:0] wr_field;

   // Timing fields use the low bits of the write word
   assign wr_field = cfg_wdata[`VGA_CNT_W-1:0];

   // Staged registers, written directly by the bus
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         staged  <= def_timing;
         pattern <= vga_pkg::pat_solid;
         enable  <= 1'b0;
      end else if (cfg_we) begin
         case (cfg_addr)
            `VGA_REG_H_ACT:   staged.h_act <= wr_field;
            `VGA_REG_H_FP:    staged.h_fp  <= wr_field;
            `VGA_REG_H_PW:    staged.h_pw  <= wr_field;
            `VGA_REG_H_BP:    staged.h_bp  <= wr_field;
            `VGA_REG_V_ACT:   staged.v_act <= wr_field;
            `VGA_REG_V_FP:    staged.v_fp  <= wr_field;
            `VGA_REG_V_PW:    staged.v_pw  <= wr_field;
            `VGA_REG_V_BP:    staged.v_bp  <= wr_field;
            `VGA_REG_PATTERN: pattern <= vga_pkg::pattern_e'(cfg_wdata[1:0]);
            `VGA_REG_CTRL:    enable  <= cfg_wdata[`VGA_CTRL_EN_BIT];
            default: ;
         endcase
      end
   end

   // Shadow copy seen by the generator and the checker
   // Follows the staged set only at a frame boundary or while idle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         timing <= def_timing;
      end else if (frame_start || !enable) begin
         timing <= staged;
      end
   end

endmodule

/* design/vga_pattern_gen.sv */
`timescale 1ns/100ps
`include "vga_consts.svh"

module vga_pattern_gen (
   input  logic                  clk,
   input  logic                  arst_n,
   input  vga_pkg::pattern_e     pattern,
   input  logic                  hsync_raw,
   input  logic                  vsync_raw,
   input  logic                  de,
   input  logic [`VGA_CNT_W-1:0] x,
   input  logic [`VGA_CNT_W-1:0] y,
   output logic [`VGA_COL_W-1:0] vga_r,
   output logic [`VGA_COL_W-1:0] vga_g,
   output logic [`VGA_COL_W-1:0] vga_b,
   output logic                  vga_hsync,
   output logic                  vga_vsync
);

   vga_pkg::rgb_t colour_next;
   vga_pkg::rgb_t colour_q;

   // Colour for the current pixel
   always_comb begin
      case (pattern)
         vga_pkg::pat_solid: colour_next = '1;
         // Three wide bars per channel bit
         vga_pkg::pat_bars: begin
            colour_next.r = {`VGA_COL_W{x[6]}};
            colour_next.g = {`VGA_COL_W{x[7]}};
            colour_next.b = {`VGA_COL_W{x[8]}};
         end
         // 8x8 squares
         vga_pkg::pat_checker: colour_next = (x[3] ^ y[3]) ? '1 : '0;
         vga_pkg::pat_ramp: begin
            colour_next.r = x[`VGA_COL_W-1:0];
            colour_next.g = x[`VGA_COL_W-1:0];
            colour_next.b = x[`VGA_COL_W-1:0];
         end
         default: colour_next = '0;
      endcase
   end

   // Output stage, colour and syncs move together
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         colour_q  <= '0;
         vga_hsync <= 1'b1;
         vga_vsync <= 1'b1;
      end else begin
         // Black outside the visible window
         colour_q  <= de ? colour_next : '0;
         vga_hsync <= hsync_raw;
         vga_vsync <= vsync_raw;
      end
   end

   assign vga_r = colour_q.r;
   assign vga_g = colour_q.g;
   assign vga_b = colour_q.b;

endmodule

/* design/vga_pkg.sv */
`include "vga_consts.svh"

package vga_pkg;

   // One full timing set
   // Each line runs active, front porch, sync, back porch
   typedef struct packed {
      logic [`VGA_CNT_W-1:0] h_act;
      logic [`VGA_CNT_W-1:0] h_fp;
      logic [`VGA_CNT_W-1:0] h_pw;
      logic [`VGA_CNT_W-1:0] h_bp;
      logic [`VGA_CNT_W-1:0] v_act;
      logic [`VGA_CNT_W-1:0] v_fp;
      logic [`VGA_CNT_W-1:0] v_pw;
      logic [`VGA_CNT_W-1:0] v_bp;
   } timing_t;

   // Pixel colour, 4 bits per channel
   typedef struct packed {
      logic [`VGA_COL_W-1:0] r;
      logic [`VGA_COL_W-1:0] g;
      logic [`VGA_COL_W-1:0] b;
   } rgb_t;

   // Test pattern selection
   typedef enum logic [1:0] {
      pat_solid   = 2'd0,
      pat_bars    = 2'd1,
      pat_checker = 2'd2,
      pat_ramp    = 2'd3
   } pattern_e;

   // Sticky checker flags
   typedef struct packed {
      logic h_width;
      logic h_period;
      logic v_width;
      logic v_period;
      logic blank_colour;
   } sync_err_t;

endpackage

/* design/vga_sync_checker.sv */
`timescale 1ns/100ps
`include "vga_consts.svh"

module vga_sync_checker (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      enable,
   input  vga_pkg::timing_t          timing,
   input  logic [`VGA_COL_W-1:0]     vga_r,
   input  logic [`VGA_COL_W-1:0]     vga_g,
   input  logic [`VGA_COL_W-1:0]     vga_b,
   input  logic                      vga_hsync,
   input  logic                      vga_vsync,
   output logic                      synchronized,
   output vga_pkg::sync_err_t        sync_err,
   output logic [`VGA_ERR_CNT_W-1:0] err_count
);

   logic prev_h;
   logic prev_v;
   logic h_fall;
   logic h_rise;
   logic v_fall;
   logic v_rise;

   // Position in clocks since the hsync fall, and in lines since the vsync fall
   logic [`VGA_CNT_W-1:0] h_cnt_q;
   logic [`VGA_CNT_W-1:0] h_pos;
   logic [`VGA_CNT_W-1:0] v_line_q;
   logic [`VGA_CNT_W-1:0] v_line;

   // Expected values, captured at the start of each line and frame
   logic [`VGA_CNT_W-1:0] exp_h_pw;
   logic [`VGA_CNT_W-1:0] exp_h_per;
   logic [`VGA_CNT_W-1:0] exp_h_start;
   logic [`VGA_CNT_W-1:0] exp_h_end;
   logic [`VGA_CNT_W-1:0] exp_v_pw;
   logic [`VGA_CNT_W-1:0] exp_v_per;
   logic [`VGA_CNT_W-1:0] exp_v_start;
   logic [`VGA_CNT_W-1:0] exp_v_end;

   logic                      in_active;
   vga_pkg::sync_err_t        new_err;
   logic [2:0]                num_new;
   logic [`VGA_ERR_CNT_W:0]   cnt_sum;

   assign h_fall = prev_h && !vga_hsync;
   assign h_rise = !prev_h && vga_hsync;
   assign v_fall = prev_v && !vga_vsync;
   assign v_rise = !prev_v && vga_vsync;

   // Position zero is the fall cycle itself
   assign h_pos  = h_fall ? '0 : h_cnt_q;
   assign v_line = v_fall ? '0 : (h_fall ? v_line_q + 1'b1 : v_line_q);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         prev_h   <= 1'b1;
         prev_v   <= 1'b1;
         h_cnt_q  <= '0;
         v_line_q <= '0;
      end else begin
         prev_h   <= vga_hsync;
         prev_v   <= vga_vsync;
         h_cnt_q  <= h_pos + 1'b1;
         v_line_q <= v_line;
      end
   end

   // Line values latched at hsync fall, frame values at vsync fall
   always_ff @(posedge clk) begin
      if (h_fall) begin
         exp_h_pw    <= timing.h_pw;
         exp_h_start <= timing.h_pw + timing.h_bp;
         exp_h_end   <= timing.h_pw + timing.h_bp + timing.h_act;
         exp_h_per   <= timing.h_pw + timing.h_bp + timing.h_act + timing.h_fp;
      end
      if (v_fall) begin
         exp_v_pw    <= timing.v_pw;
         exp_v_start <= timing.v_pw + timing.v_bp;
         exp_v_end   <= timing.v_pw + timing.v_bp + timing.v_act;
         exp_v_per   <= timing.v_pw + timing.v_bp + timing.v_act + timing.v_fp;
      end
   end

   // Own visible window, everything else is blanking
   assign in_active = (h_pos >= exp_h_start) && (h_pos < exp_h_end) &&
                      (v_line >= exp_v_start) && (v_line < exp_v_end);

   // Mismatches this cycle
   always_comb begin
      new_err.h_width      = synchronized && h_rise && (h_pos != exp_h_pw);
      new_err.h_period     = synchronized && h_fall && (h_cnt_q != exp_h_per);
      new_err.v_width      = synchronized && v_rise && (v_line != exp_v_pw);
      new_err.v_period     = synchronized && v_fall && (v_line_q + 1'b1 != exp_v_per);
      new_err.blank_colour = synchronized && !in_active && (|{vga_r, vga_g, vga_b});
   end

   // Several flags may fire in one cycle
   always_comb begin
      num_new = '0;
      for (int i = 0; i < $bits(new_err); i++) begin
         num_new = num_new + 3'(new_err[i]);
      end
      cnt_sum = {1'b0, err_count} + (`VGA_ERR_CNT_W+1)'(num_new);
   end

   // Lock on the first vsync fall after enable
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         synchronized <= 1'b0;
         sync_err     <= '0;
         err_count    <= '0;
      end else begin
         if (!enable) begin
            synchronized <= 1'b0;
         end else if (v_fall) begin
            synchronized <= 1'b1;
         end
         sync_err <= sync_err | new_err;
         // Saturate instead of wrapping
         err_count <= cnt_sum[`VGA_ERR_CNT_W] ? '1 : cnt_sum[`VGA_ERR_CNT_W-1:0];
      end
   end

endmodule

/* design/vga_timing_gen.sv */
`timescale 1ns/100ps
`include "vga_consts.svh"

module vga_timing_gen (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  enable,
   input  vga_pkg::timing_t      timing,
   output logic                  hsync_raw,
   output logic                  vsync_raw,
   output logic                  de,
   output logic                  frame_start,
   output logic [`VGA_CNT_W-1:0] x,
   output logic [`VGA_CNT_W-1:0] y
);

   logic                  run;
   logic [`VGA_CNT_W-1:0] h_cnt;
   logic [`VGA_CNT_W-1:0] v_cnt;

   // Running sums from the sync start of each line and frame
   logic [`VGA_CNT_W-1:0] h_act_start;
   logic [`VGA_CNT_W-1:0] h_act_end;
   logic [`VGA_CNT_W-1:0] h_total;
   logic [`VGA_CNT_W-1:0] v_act_start;
   logic [`VGA_CNT_W-1:0] v_act_end;
   logic [`VGA_CNT_W-1:0] v_total;

   logic h_last;
   logic v_last;
   logic h_vis;
   logic v_vis;

   // Counting starts at the sync pulse, then back porch, active, front porch
   assign h_act_start = timing.h_pw + timing.h_bp;
   assign h_act_end   = h_act_start + timing.h_act;
   assign h_total     = h_act_end + timing.h_fp;
   assign v_act_start = timing.v_pw + timing.v_bp;
   assign v_act_end   = v_act_start + timing.v_act;
   assign v_total     = v_act_end + timing.v_fp;

   assign h_last = (h_cnt == h_total - 1'b1);
   assign v_last = (v_cnt == v_total - 1'b1);

   // Pixel and line counters
   // run lags enable by one clock so the first pixel is (0,0)
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         run   <= 1'b0;
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (!enable) begin
         run   <= 1'b0;
         h_cnt <= '0;
         v_cnt <= '0;
      end else begin
         run <= 1'b1;
         if (run) begin
            if (h_last) begin
               h_cnt <= '0;
               // Frame wrap at the end of the last line
               if (v_last) begin
                  v_cnt <= '0;
               end else begin
                  v_cnt <= v_cnt + 1'b1;
               end
            end else begin
               h_cnt <= h_cnt + 1'b1;
            end
         end
      end
   end

   // Visible windows
   assign h_vis = (h_cnt >= h_act_start) && (h_cnt < h_act_end);
   assign v_vis = (v_cnt >= v_act_start) && (v_cnt < v_act_end);

   // Active-low syncs, held high while idle
   assign hsync_raw = !(run && (h_cnt < timing.h_pw));
   assign vsync_raw = !(run && (v_cnt < timing.v_pw));

   assign de          = run && h_vis && v_vis;
   assign frame_start = run && (h_cnt == '0) && (v_cnt == '0);

   // Coordinates relative to the first visible pixel
   assign x = h_cnt - h_act_start;
   assign y = v_cnt - v_act_start;

endmodule

/* design/vga_top.sv */
`timescale 1ns/100ps
`include "vga_consts.svh"

module vga_top (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      cfg_we,
   input  logic [`VGA_ADDR_W-1:0]    cfg_addr,
   input  logic [`VGA_DATA_W-1:0]    cfg_wdata,
   output logic [`VGA_COL_W-1:0]     vga_r,
   output logic [`VGA_COL_W-1:0]     vga_g,
   output logic [`VGA_COL_W-1:0]     vga_b,
   output logic                      vga_hsync,
   output logic                      vga_vsync,
   output logic                      synchronized,
   output vga_pkg::sync_err_t        sync_err,
   output logic [`VGA_ERR_CNT_W-1:0] err_count
);

   // Configuration outputs
   vga_pkg::timing_t  timing;
   vga_pkg::pattern_e pattern;
   logic              enable;

   // Raw timing, one clock ahead of the pins
   logic                  frame_start;
   logic                  hsync_raw;
   logic                  vsync_raw;
   logic                  de;
   logic [`VGA_CNT_W-1:0] x;
   logic [`VGA_CNT_W-1:0] y;

   vga_cfg_regs u_cfg_regs (
      .clk         (clk),
      .arst_n      (arst_n),
      .cfg_we      (cfg_we),
      .cfg_addr    (cfg_addr),
      .cfg_wdata   (cfg_wdata),
      .frame_start (frame_start),
      .timing      (timing),
      .pattern     (pattern),
      .enable      (enable)
   );

   vga_timing_gen u_timing_gen (
      .clk         (clk),
      .arst_n      (arst_n),
      .enable      (enable),
      .timing      (timing),
      .hsync_raw   (hsync_raw),
      .vsync_raw   (vsync_raw),
      .de          (de),
      .frame_start (frame_start),
      .x           (x),
      .y           (y)
   );

   vga_pattern_gen u_pattern_gen (
      .clk       (clk),
      .arst_n    (arst_n),
      .pattern   (pattern),
      .hsync_raw (hsync_raw),
      .vsync_raw (vsync_raw),
      .de        (de),
      .x         (x),
      .y         (y),
      .vga_r     (vga_r),
      .vga_g     (vga_g),
      .vga_b     (vga_b),
      .vga_hsync (vga_hsync),
      .vga_vsync (vga_vsync)
   );

   // Checker taps the pins, not the raw timing
   vga_sync_checker u_sync_checker (
      .clk          (clk),
      .arst_n       (arst_n),
      .enable       (enable),
      .timing       (timing),
      .vga_r        (vga_r),
      .vga_g        (vga_g),
      .vga_b        (vga_b),
      .vga_hsync    (vga_hsync),
      .vga_vsync    (vga_vsync),
      .synchronized (synchronized),
      .sync_err     (sync_err),
      .err_count    (err_count)
   );

endmodule

/* include/vga_consts.svh */
`ifndef VGA_CONSTS_SVH
`define VGA_CONSTS_SVH

// Field widths
`define VGA_CNT_W       11
`define VGA_COL_W       4
`define VGA_ADDR_W      4
`define VGA_DATA_W      16
`define VGA_ERR_CNT_W   16

// Default 640x480 horizontal timing in pixel clocks
`define VGA_DEF_H_ACT   640
`define VGA_DEF_H_FP    16
`define VGA_DEF_H_PW    96
`define VGA_DEF_H_BP    48

// Default 640x480 vertical timing in lines
`define VGA_DEF_V_ACT   480
`define VGA_DEF_V_FP    10
`define VGA_DEF_V_PW    2
`define VGA_DEF_V_BP    33

// Register map
`define VGA_REG_H_ACT   4'd0
`define VGA_REG_H_FP    4'd1
`define VGA_REG_H_PW    4'd2
`define VGA_REG_H_BP    4'd3
`define VGA_REG_V_ACT   4'd4
`define VGA_REG_V_FP    4'd5
`define VGA_REG_V_PW    4'd6
`define VGA_REG_V_BP    4'd7
`define VGA_REG_PATTERN 4'd8
`define VGA_REG_CTRL    4'd9

// Enable bit of the control register
`define VGA_CTRL_EN_BIT 0

`endif

/* verification/vga_top_tb.sv */
`timescale 1ns/100ps
`include "vga_consts.svh"

module vga_top_tb;

   // Upper bound on clocks spent observing one entry
   localparam int frame_limit = 200000;

   typedef struct {
      vga_pkg::timing_t  tm;
      vga_pkg::pattern_e pat;
      int                frames;
      bit                live;
   } entry_t;

   logic                      clk;
   logic                      arst_n;
   logic                      cfg_we;
   logic [`VGA_ADDR_W-1:0]    cfg_addr;
   logic [`VGA_DATA_W-1:0]    cfg_wdata;
   logic [`VGA_COL_W-1:0]     vga_r;
   logic [`VGA_COL_W-1:0]     vga_g;
   logic [`VGA_COL_W-1:0]     vga_b;
   logic                      vga_hsync;
   logic                      vga_vsync;
   logic                      synchronized;
   vga_pkg::sync_err_t        sync_err;
   logic [`VGA_ERR_CNT_W-1:0] err_count;

   // Stimulus table, and register writes waiting for a free clock
   entry_t                             tab[$];
   logic [`VGA_ADDR_W+`VGA_DATA_W-1:0] wq[$];

   // Reference model, position counted from the last sync falls
   vga_pkg::timing_t  cur;
   vga_pkg::timing_t  nxt;
   vga_pkg::pattern_e pat;
   bit                track;
   bit                sync_chk;
   int                hc;
   int                vc;
   int                frames;
   logic              prev_h;
   logic              prev_v;
   logic              h_fall;
   logic              h_rise;
   logic              v_fall;
   logic              v_rise;

   vga_top u_vga_top (
      .clk          (clk),
      .arst_n       (arst_n),
      .cfg_we       (cfg_we),
      .cfg_addr     (cfg_addr),
      .cfg_wdata    (cfg_wdata),
      .vga_r        (vga_r),
      .vga_g        (vga_g),
      .vga_b        (vga_b),
      .vga_hsync    (vga_hsync),
      .vga_vsync    (vga_vsync),
      .synchronized (synchronized),
      .sync_err     (sync_err),
      .err_count    (err_count)
   );

   // 8 ns pixel clock
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic int line_clocks(input vga_pkg::timing_t t);
      return int'(t.h_act) + int'(t.h_fp) + int'(t.h_pw) + int'(t.h_bp);
   endfunction

   function automatic int frame_lines(input vga_pkg::timing_t t);
      return int'(t.v_act) + int'(t.v_fp) + int'(t.v_pw) + int'(t.v_bp);
   endfunction

   // Colour of visible pixel (x,y) for each pattern
   function automatic logic [11:0] expected_colour(input vga_pkg::pattern_e p,
                                                   input int x, input int y);
      case (p)
         vga_pkg::pat_solid:   return 12'hfff;
         vga_pkg::pat_bars:    return {{4{x[6]}}, {4{x[7]}}, {4{x[8]}}};
         vga_pkg::pat_checker: return (x[3] ^ y[3]) ? 12'hfff : 12'h000;
         default:              return {x[3:0], x[3:0], x[3:0]};
      endcase
   endfunction

   task automatic stop_on_failure();
      $display("FAIL: see errors above");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
         stop_on_failure();
      end
   endtask

   task automatic queue_write(input logic [`VGA_ADDR_W-1:0] addr,
                              input logic [`VGA_DATA_W-1:0] data);
      wq.push_back({addr, data});
   endtask

   task automatic queue_timing(input vga_pkg::timing_t t);
      queue_write(`VGA_REG_H_ACT, 16'(t.h_act));
      queue_write(`VGA_REG_H_FP, 16'(t.h_fp));
      queue_write(`VGA_REG_H_PW, 16'(t.h_pw));
      queue_write(`VGA_REG_H_BP, 16'(t.h_bp));
      queue_write(`VGA_REG_V_ACT, 16'(t.v_act));
      queue_write(`VGA_REG_V_FP, 16'(t.v_fp));
      queue_write(`VGA_REG_V_PW, 16'(t.v_pw));
      queue_write(`VGA_REG_V_BP, 16'(t.v_bp));
   endtask

   // Pins against the model at the current position
   task automatic check_pixel();
      int          x0;
      int          y0;
      logic [11:0] exp_rgb;
      x0 = int'(cur.h_pw) + int'(cur.h_bp);
      y0 = int'(cur.v_pw) + int'(cur.v_bp);
      check("vga_hsync", vga_hsync, hc >= int'(cur.h_pw));
      check("vga_vsync", vga_vsync, vc >= int'(cur.v_pw));
      exp_rgb = '0;
      if (hc >= x0 && hc < x0 + int'(cur.h_act) && vc >= y0 && vc < y0 + int'(cur.v_act)) begin
         exp_rgb = expected_colour(pat, hc - x0, vc - y0);
      end
      check("vga_rgb", {vga_r, vga_g, vga_b}, exp_rgb);
      if (sync_chk) begin
         check("synchronized", synchronized, 1'b1);
      end
   endtask

   // Advance the model by one sampled clock
   task automatic update_model();
      hc++;
      if (h_fall) begin
         check("hsync_period", hc, line_clocks(cur));
         hc = 0;
         vc++;
         if (v_fall) begin
            check("vsync_period", vc, frame_lines(cur));
            vc = 0;
            frames++;
            // New shadow set applies from this frame on
            cur = nxt;
         end
      end
      if (h_rise) begin
         check("hsync_width", hc, cur.h_pw);
      end
      if (v_rise) begin
         check("vsync_width", vc, cur.v_pw);
      end
      check_pixel();
      if (hc > 2 * line_clocks(cur)) begin
         $display("Timeout: hsync falling edge never came");
         stop_on_failure();
      end
      if (vc > 2 * frame_lines(cur)) begin
         $display("Timeout: vsync falling edge never came");
         stop_on_failure();
      end
   endtask

   // Sample on the falling edge, then drive the next input change
   task automatic step_clock();
      @(negedge clk);
      h_fall = prev_h && !vga_hsync;
      h_rise = !prev_h && vga_hsync;
      v_fall = prev_v && !vga_vsync;
      v_rise = !prev_v && vga_vsync;
      if (track) begin
         update_model();
      end
      prev_h = vga_hsync;
      prev_v = vga_vsync;
      // One queued write per clock
      if (wq.size() > 0) begin
         {cfg_addr, cfg_wdata} = wq.pop_front();
         cfg_we = 1'b1;
      end else begin
         cfg_we = 1'b0;
      end
   endtask

   task automatic add_entry(input int ha, input int hf, input int hp, input int hb,
                            input int va, input int vf, input int vp, input int vb,
                            input vga_pkg::pattern_e p, input int n, input bit live);
      entry_t e;
      e.tm.h_act = `VGA_CNT_W'(ha);
      e.tm.h_fp  = `VGA_CNT_W'(hf);
      e.tm.h_pw  = `VGA_CNT_W'(hp);
      e.tm.h_bp  = `VGA_CNT_W'(hb);
      e.tm.v_act = `VGA_CNT_W'(va);
      e.tm.v_fp  = `VGA_CNT_W'(vf);
      e.tm.v_pw  = `VGA_CNT_W'(vp);
      e.tm.v_bp  = `VGA_CNT_W'(vb);
      e.pat      = p;
      e.frames   = n;
      e.live     = live;
      tab.push_back(e);
   endtask

   task automatic run_entry(input entry_t e);
      int guard;
      int target;
      nxt = e.tm;
      if (!e.live) begin
         // Reprogram while idle, the shadow follows the staged set
         track    = 1'b0;
         sync_chk = 1'b0;
         queue_write(`VGA_REG_CTRL, 16'h0000);
         queue_timing(e.tm);
         queue_write(`VGA_REG_PATTERN, 16'(e.pat));
         queue_write(`VGA_REG_CTRL, 16'h0001);
         while (wq.size() > 0) begin
            step_clock();
         end
         guard = 0;
         do begin
            step_clock();
            guard++;
         end while (!v_fall && guard < 64);
         if (!v_fall) begin
            $display("Timeout: vsync never fell within 64 clocks of enable");
            stop_on_failure();
         end
         // Enable register, counter start, pattern register
         check("startup_clocks", guard, 3);
         check("hsync_fall_at_frame_start", h_fall, 1'b1);
         check("synchronized", synchronized, 1'b0);
         cur   = e.tm;
         pat   = e.pat;
         hc    = 0;
         vc    = 0;
         track = 1'b1;
         check_pixel();
         sync_chk = 1'b1;
      end else begin
         // Rewrite the timing during line 1 of a running frame
         guard = 0;
         while (!(vc == 1 && hc == 0) && guard < 2 * line_clocks(cur) + 2) begin
            step_clock();
            guard++;
         end
         if (!(vc == 1 && hc == 0)) begin
            $display("Timeout: second line of the running frame never started");
            stop_on_failure();
         end
         queue_timing(e.tm);
      end
      // A live entry also finishes the frame it was written in
      target = e.live ? e.frames + 1 : e.frames;
      frames = 0;
      guard  = 0;
      while (frames < target && guard < frame_limit) begin
         step_clock();
         guard++;
      end
      if (frames < target) begin
         $display("Timeout: only %0d of %0d frames seen", frames, target);
         stop_on_failure();
      end
      check("sync_err", sync_err, '0);
      check("err_count", err_count, '0);
   endtask

   initial begin
      arst_n    = 1'b0;
      cfg_we    = 1'b0;
      cfg_addr  = '0;
      cfg_wdata = '0;
      track     = 1'b0;
      sync_chk  = 1'b0;
      hc        = 0;
      vc        = 0;
      frames    = 0;
      prev_h    = 1'b1;
      prev_v    = 1'b1;
      h_fall    = 1'b0;
      h_rise    = 1'b0;
      v_fall    = 1'b0;
      v_rise    = 1'b0;
      cur       = '0;
      nxt       = '0;
      pat       = vga_pkg::pat_solid;
      repeat (16) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      repeat (4) step_clock();

      // Idle state after reset, nothing enabled yet
      check("vga_hsync", vga_hsync, 1'b1);
      check("vga_vsync", vga_vsync, 1'b1);
      check("vga_rgb", {vga_r, vga_g, vga_b}, 12'h000);
      check("synchronized", synchronized, 1'b0);
      check("sync_err", sync_err, '0);
      check("err_count", err_count, '0);

      // h act/fp/pw/bp, v act/fp/pw/bp, pattern, frames, written mid-frame
      add_entry(16, 2, 4, 3, 6, 1, 2, 1, vga_pkg::pat_solid, 2, 1'b0);
      add_entry(40, 2, 6, 5, 20, 1, 2, 1, vga_pkg::pat_checker, 2, 1'b0);
      // Live entries keep the pattern that is running
      add_entry(32, 4, 3, 6, 18, 2, 3, 2, vga_pkg::pat_checker, 2, 1'b1);
      add_entry(300, 8, 12, 10, 4, 1, 1, 1, vga_pkg::pat_bars, 1, 1'b0);
      add_entry(20, 1, 1, 1, 3, 1, 1, 1, vga_pkg::pat_ramp, 3, 1'b0);
      add_entry(24, 3, 5, 4, 10, 2, 3, 2, vga_pkg::pat_ramp, 2, 1'b1);

      foreach (tab[i]) begin
         run_entry(tab[i]);
      end

      $display("PASS: all tests");
      $finish;
   end

endmodule

/* vga_top.f */
+incdir+include
design/vga_pkg.sv
design/vga_cfg_regs.sv
design/vga_timing_gen.sv
design/vga_pattern_gen.sv
design/vga_sync_checker.sv
design/vga_top.sv
verification/vga_top_tb.sv
